/* common/shift_macros.svh */
// shift unit constants
`ifndef SHIFT_MACROS_SVH
`define SHIFT_MACROS_SVH

// internal operation codes, carried through the queue
`define CMD_SLL    3'd0
`define CMD_SRL    3'd1
`define CMD_SRA    3'd2
`define CMD_SLLV   3'd3
`define CMD_SRLV   3'd4
`define CMD_SRAV   3'd5
`define CMD_LUI    3'd6

// mips primary opcodes
`define OP_SPECIAL 6'h00
`define OP_LUI     6'h0f

// funct field values under OP_SPECIAL
`define FUNCT_SLL  6'h00
`define FUNCT_SRL  6'h02
`define FUNCT_SRA  6'h03
`define FUNCT_SLLV 6'h04
`define FUNCT_SRLV 6'h06
`define FUNCT_SRAV 6'h07

// power of two, 2 to 16
`define SHIFT_QUEUE_DEPTH 4

`endif

/* common/shift_pkg.sv */
// shift unit types
package shift_pkg;

    // one 32-bit instruction word, seen as r-type or i-type
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } i;
    } mips_instr_t;

endpackage

/* hdl/shift_issue.sv */
// shift instruction issue
`timescale 1ns/1ps
`include "shift_macros.svh"

module shift_issue
    import shift_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        in_req,
    input  mips_instr_t in_instr,
    input  logic [31:0] in_rs_val,
    input  logic [31:0] in_rt_val,
    output logic        in_ack,
    input  logic        full,
    output logic        push,
    output logic [2:0]  push_cmd,
    output logic [31:0] push_instr,
    output logic [31:0] push_a,
    output logic [31:0] push_b
);

    logic is_shift;
    logic accept;

    // decode opcode and funct into an internal command
    always_comb begin
        is_shift = 1'b1;
        push_cmd = `CMD_SLL;
        if (in_instr.r.opcode == `OP_SPECIAL) begin
            case (in_instr.r.funct)
                `FUNCT_SLL:  push_cmd = `CMD_SLL;
                `FUNCT_SRL:  push_cmd = `CMD_SRL;
                `FUNCT_SRA:  push_cmd = `CMD_SRA;
                `FUNCT_SLLV: push_cmd = `CMD_SLLV;
                `FUNCT_SRLV: push_cmd = `CMD_SRLV;
                `FUNCT_SRAV: push_cmd = `CMD_SRAV;
                default:     is_shift = 1'b0;
            endcase
        end else if (in_instr.i.opcode == `OP_LUI) begin
            push_cmd = `CMD_LUI;
        end else begin
            is_shift = 1'b0;
        end
    end

    // new request seen while ack is low
    // non-shift words need no queue space
    assign accept = in_req && !in_ack && (!is_shift || !full);
    assign push   = accept && is_shift;

    assign push_instr = in_instr;
    assign push_a     = in_rs_val;
    // lui immediate rides in operand b
    assign push_b     = (push_cmd == `CMD_LUI) ? {16'h0000, in_instr.i.imm} : in_rt_val;

    // four-phase ack
    always_ff @(posedge clk) begin
        if (rst) begin
            in_ack <= 1'b0;
        end else if (!in_ack) begin
            if (accept) begin
                in_ack <= 1'b1;
            end
        end else if (!in_req) begin
            in_ack <= 1'b0;
        end
    end

endmodule

/* hdl/shift_queue.sv */
// decoded shift operation queue
`timescale 1ns/1ps
`include "shift_macros.svh"

module shift_queue (
    input  logic        clk,
    input  logic        rst,
    input  logic        push,
    input  logic [2:0]  push_cmd,
    input  logic [31:0] push_instr,
    input  logic [31:0] push_a,
    input  logic [31:0] push_b,
    output logic        full,
    input  logic        pop,
    output logic [2:0]  pop_cmd,
    output logic [31:0] pop_instr,
    output logic [31:0] pop_a,
    output logic [31:0] pop_b,
    output logic        empty
);

    localparam int DEPTH   = `SHIFT_QUEUE_DEPTH;
    localparam int PTR_W   = $clog2(DEPTH);
    localparam int CNT_W   = PTR_W + 1;
    localparam int ENTRY_W = 3 + 32 * 3;

    logic [ENTRY_W-1:0] mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;

    // storage, written on push only
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= {push_cmd, push_instr, push_a, push_b};
        end
    end

    // head entry is always on the pop outputs
    assign {pop_cmd, pop_instr, pop_a, pop_b} = mem[rd_ptr];

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);

endmodule

/* shift_exec/block_shift.sv */
// left and right barrel shifter
`timescale 1ns/1ps
`include "shift_macros.svh"

module block_shift
    import shift_pkg::*;
(
    input  logic [2:0]  cmd,
    input  mips_instr_t instr,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic [31:0] shift_left,
    output logic [31:0] shift_right
);

    logic [4:0] left_amt;
    logic [4:0] right_amt;
    logic       right_arith;
    logic [31:0] fill;

    // left amount, variable form takes rs low bits
    always_comb begin
        case (cmd)
            `CMD_SLLV: left_amt = a[4:0];
            `CMD_LUI:  left_amt = 5'd16;
            default:   left_amt = instr.r.shamt;
        endcase
    end

    // right amount
    always_comb begin
        case (cmd)
            `CMD_SRLV,
            `CMD_SRAV: right_amt = a[4:0];
            default:   right_amt = instr.r.shamt;
        endcase
    end

    assign right_arith = (cmd == `CMD_SRA) || (cmd == `CMD_SRAV);

    // sign fill for arithmetic shifts, zero otherwise
    assign fill = {32{right_arith & b[31]}};

    assign shift_left = b << left_amt;

    // logical shift of b, vacated top bits taken from fill
    assign shift_right = (b >> right_amt) | ~(32'hffff_ffff >> right_amt) & fill;

endmodule

/* shift_exec/shift_retire.sv */
// shift result retire
`timescale 1ns/1ps
`include "shift_macros.svh"

module shift_retire
    import shift_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        empty,
    output logic        pop,
    input  logic [2:0]  pop_cmd,
    input  logic [31:0] pop_instr,
    input  logic [31:0] pop_a,
    input  logic [31:0] pop_b,
    output logic        res_req,
    input  logic        res_ack,
    output logic [31:0] res_data,
    output logic [4:0]  res_dest
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_REQ  = 2'd1;
    localparam logic [1:0] ST_DROP = 2'd2;

    logic [1:0]  state;
    mips_instr_t head_instr;
    logic [31:0] left_res;
    logic [31:0] right_res;
    logic        use_left;

    assign head_instr = pop_instr;

    block_shift shifter (
        .cmd         (pop_cmd),
        .instr       (head_instr),
        .a           (pop_a),
        .b           (pop_b),
        .shift_left  (left_res),
        .shift_right (right_res)
    );

    assign use_left = (pop_cmd == `CMD_SLL) || (pop_cmd == `CMD_SLLV) ||
                      (pop_cmd == `CMD_LUI);

    // take one entry whenever idle
    assign pop = (state == ST_IDLE) && !empty;

    // result and destination, loaded with the pop
    always_ff @(posedge clk) begin
        if (pop) begin
            res_data <= use_left ? left_res : right_res;
            // lui targets rt, r-type shifts target rd
            res_dest <= (pop_cmd == `CMD_LUI) ? head_instr.i.rt : head_instr.r.rd;
        end
    end

    // output four-phase handshake
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= ST_IDLE;
            res_req <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (pop) begin
                        res_req <= 1'b1;
                        state   <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (res_ack) begin
                        res_req <= 1'b0;
                        state   <= ST_DROP;
                    end
                end
                ST_DROP: begin
                    // wait for the receiver to release ack
                    if (!res_ack) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    res_req <= 1'b0;
                    state   <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

/* hdl/shift_unit_top.sv */
// shift execution unit
`timescale 1ns/1ps

module shift_unit_top
    import shift_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        in_req,
    input  mips_instr_t in_instr,
    input  logic [31:0] in_rs_val,
    input  logic [31:0] in_rt_val,
    output logic        in_ack,
    output logic        res_req,
    input  logic        res_ack,
    output logic [31:0] res_data,
    output logic [4:0]  res_dest
);

    // issue to queue
    logic        push;
    logic [2:0]  push_cmd;
    logic [31:0] push_instr;
    logic [31:0] push_a;
    logic [31:0] push_b;
    logic        full;

    // queue to retire
    logic        pop;
    logic [2:0]  pop_cmd;
    logic [31:0] pop_instr;
    logic [31:0] pop_a;
    logic [31:0] pop_b;
    logic        empty;

    shift_issue issue (
        .clk        (clk),
        .rst        (rst),
        .in_req     (in_req),
        .in_instr   (in_instr),
        .in_rs_val  (in_rs_val),
        .in_rt_val  (in_rt_val),
        .in_ack     (in_ack),
        .full       (full),
        .push       (push),
        .push_cmd   (push_cmd),
        .push_instr (push_instr),
        .push_a     (push_a),
        .push_b     (push_b)
    );

    shift_queue queue (
        .clk        (clk),
        .rst        (rst),
        .push       (push),
        .push_cmd   (push_cmd),
        .push_instr (push_instr),
        .push_a     (push_a),
        .push_b     (push_b),
        .full       (full),
        .pop        (pop),
        .pop_cmd    (pop_cmd),
        .pop_instr  (pop_instr),
        .pop_a      (pop_a),
        .pop_b      (pop_b),
        .empty      (empty)
    );

    shift_retire retire (
        .clk       (clk),
        .rst       (rst),
        .empty     (empty),
        .pop       (pop),
        .pop_cmd   (pop_cmd),
        .pop_instr (pop_instr),
        .pop_a     (pop_a),
        .pop_b     (pop_b),
        .res_req   (res_req),
        .res_ack   (res_ack),
        .res_data  (res_data),
        .res_dest  (res_dest)
    );

endmodule

/* tests/shift_unit_asserts.sv */
// shift unit handshake assertions
`timescale 1ns/1ps

module shift_unit_asserts (
    input logic        clk,
    input logic        rst,
    input logic        in_req,
    input logic        in_ack,
    input logic        res_req,
    input logic        res_ack,
    input logic [31:0] res_data,
    input logic [4:0]  res_dest
);

    // both outputs low after a reset edge
    reset_clears: assert property (@(posedge clk) rst |=> !in_ack && !res_req)
        else $error("in_ack or res_req high after reset");

    // ack rises one edge after req was seen
    in_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(in_ack) |-> $past(in_req))
        else $error("in_ack rose without in_req");

    res_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(res_ack) |-> res_req)
        else $error("res_ack rose without res_req");

    // result held for the whole request
    result_stable: assert property (@(posedge clk) disable iff (rst)
        res_req && $past(res_req) |-> $stable(res_data) && $stable(res_dest))
        else $error("res_data or res_dest changed while res_req was high");

endmodule

bind shift_unit_top shift_unit_asserts handshake_asserts (
    .clk      (clk),
    .rst      (rst),
    .in_req   (in_req),
    .in_ack   (in_ack),
    .res_req  (res_req),
    .res_ack  (res_ack),
    .res_data (res_data),
    .res_dest (res_dest)
);

/* tests/shift_unit_checker.sv */
// shift unit result checker
`timescale 1ns/1ps
`include "shift_macros.svh"

module shift_unit_checker
    import shift_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        in_req,
    input  mips_instr_t in_instr,
    input  logic [31:0] in_rs_val,
    input  logic [31:0] in_rt_val,
    input  logic        in_ack,
    input  logic        res_req,
    input  logic [31:0] res_data,
    input  logic [4:0]  res_dest,
    output int          mismatch_count,
    output int          extra_count,
    output int          pending
);

    logic [31:0] exp_data_q[$];
    logic [4:0]  exp_dest_q[$];
    mips_instr_t held_instr;
    logic [31:0] held_rs;
    logic [31:0] held_rt;
    logic        prev_in_ack;
    logic        prev_res_req;

    // MIPS shift semantics, returns 0 for a word that yields no result
    function automatic logic predict(input mips_instr_t w, input logic [31:0] rs,
                                     input logic [31:0] rt, output logic [31:0] data,
                                     output logic [4:0] dest);
        logic [4:0] amt;
        predict = 1'b1;
        data    = '0;
        dest    = w.r.rd;
        amt     = w.r.shamt;
        if (w.i.opcode == `OP_LUI) begin
            data = {w.i.imm, 16'h0000};
            dest = w.i.rt;
        end else if (w.r.opcode == `OP_SPECIAL) begin
            if (w.r.funct == `FUNCT_SLLV || w.r.funct == `FUNCT_SRLV ||
                w.r.funct == `FUNCT_SRAV) begin
                amt = rs[4:0];
            end
            case (w.r.funct)
                `FUNCT_SLL, `FUNCT_SLLV: data = rt << amt;
                `FUNCT_SRL, `FUNCT_SRLV: data = rt >> amt;
                `FUNCT_SRA, `FUNCT_SRAV: data = $unsigned($signed(rt) >>> amt);
                default:                 predict = 1'b0;
            endcase
        end else begin
            predict = 1'b0;
        end
    endfunction

    always @(posedge clk) begin
        logic [31:0] exp_data;
        logic [4:0]  exp_dest;
        if (rst) begin
            prev_in_ack    <= 1'b0;
            prev_res_req   <= 1'b0;
            mismatch_count <= 0;
            extra_count    <= 0;
            pending        <= 0;
        end else begin
            // the word is held while req waits for ack
            if (in_req && !in_ack) begin
                held_instr <= in_instr;
                held_rs    <= in_rs_val;
                held_rt    <= in_rt_val;
            end
            if (in_ack && !prev_in_ack) begin
                if (predict(held_instr, held_rs, held_rt, exp_data, exp_dest)) begin
                    exp_data_q.push_back(exp_data);
                    exp_dest_q.push_back(exp_dest);
                end
            end
            if (res_req && !prev_res_req) begin
                if (exp_data_q.size() == 0) begin
                    extra_count <= extra_count + 1;
                    $display("[FAIL] %0t: result %h to r%0d with nothing pending",
                             $time, res_data, res_dest);
                end else begin
                    exp_data = exp_data_q.pop_front();
                    exp_dest = exp_dest_q.pop_front();
                    if (res_data !== exp_data || res_dest !== exp_dest) begin
                        mismatch_count <= mismatch_count + 1;
                        $display("[FAIL] %0t: got %h to r%0d, expected %h to r%0d",
                                 $time, res_data, res_dest, exp_data, exp_dest);
                    end
                end
            end
            prev_in_ack  <= in_ack;
            prev_res_req <= res_req;
            pending      <= exp_data_q.size();
        end
    end

endmodule

/* tests/shift_unit_tb.sv */
// shift unit testbench
`timescale 1ns/1ps
`include "shift_macros.svh"

module shift_unit_tb
    import shift_pkg::*;
();

    localparam int NUM_WORDS       = 400;
    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 8;
    localparam int CYCLES_PER_WORD = 20;
    localparam int SEED            = 2776;
    localparam int DRAIN_CYCLES    = (`SHIFT_QUEUE_DEPTH + 2) * 2 * CYCLES_PER_WORD;
    localparam int WATCHDOG_NS     = (RESET_CYCLES + NUM_WORDS * CYCLES_PER_WORD) * CLK_PERIOD;

    logic        clk;
    logic        rst;
    logic        in_req;
    mips_instr_t in_instr;
    logic [31:0] in_rs_val;
    logic [31:0] in_rt_val;
    logic        in_ack;
    logic        res_req;
    logic        res_ack;
    logic [31:0] res_data;
    logic [4:0]  res_dest;
    int          mismatch_count;
    int          extra_count;
    int          pending;
    int          reset_errors;

    shift_unit_top shift_unit_inst (
        .clk       (clk),
        .rst       (rst),
        .in_req    (in_req),
        .in_instr  (in_instr),
        .in_rs_val (in_rs_val),
        .in_rt_val (in_rt_val),
        .in_ack    (in_ack),
        .res_req   (res_req),
        .res_ack   (res_ack),
        .res_data  (res_data),
        .res_dest  (res_dest)
    );

    shift_unit_checker result_checker (
        .clk            (clk),
        .rst            (rst),
        .in_req         (in_req),
        .in_instr       (in_instr),
        .in_rs_val      (in_rs_val),
        .in_rt_val      (in_rt_val),
        .in_ack         (in_ack),
        .res_req        (res_req),
        .res_data       (res_data),
        .res_dest       (res_dest),
        .mismatch_count (mismatch_count),
        .extra_count    (extra_count),
        .pending        (pending)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // random word with about one in eight not a shift
    task automatic make_word(output mips_instr_t word, output logic [31:0] rs,
                             output logic [31:0] rt);
        logic [31:0] rnd;
        int          kind;
        word = $urandom;
        rs   = $urandom;
        rt   = $urandom;
        rnd  = $urandom;
        kind = int'(rnd % 32'd7);
        if (rnd[30:28] == 3'd0) begin
            if (rnd[27]) begin
                word.r.opcode = `OP_SPECIAL;
                // add, sub, or, slt
                case (rnd[26:25])
                    2'd0:    word.r.funct = 6'h20;
                    2'd1:    word.r.funct = 6'h22;
                    2'd2:    word.r.funct = 6'h25;
                    default: word.r.funct = 6'h2a;
                endcase
            end else begin
                // load and store opcode range
                word.i.opcode = {1'b1, rnd[24:20]};
            end
        end else if (kind == 6) begin
            word.i.opcode = `OP_LUI;
        end else begin
            word.r.opcode = `OP_SPECIAL;
            case (kind)
                0:       word.r.funct = `FUNCT_SLL;
                1:       word.r.funct = `FUNCT_SRL;
                2:       word.r.funct = `FUNCT_SRA;
                3:       word.r.funct = `FUNCT_SLLV;
                4:       word.r.funct = `FUNCT_SRLV;
                default: word.r.funct = `FUNCT_SRAV;
            endcase
        end
    endtask

    // one four-phase exchange from falling edge to falling edge
    task automatic send_word(input mips_instr_t word, input logic [31:0] rs,
                             input logic [31:0] rt);
        in_instr  = word;
        in_rs_val = rs;
        in_rt_val = rt;
        in_req    = 1'b1;
        @(negedge clk);
        while (!in_ack) @(negedge clk);
        in_req = 1'b0;
        @(negedge clk);
        while (in_ack) @(negedge clk);
    endtask

    initial begin
        int          seed_ret;
        int          gap;
        int          drain_count;
        mips_instr_t word;
        logic [31:0] rs;
        logic [31:0] rt;
        seed_ret     = $urandom(SEED);
        rst          = 1'b1;
        in_req       = 1'b0;
        in_instr     = '0;
        in_rs_val    = '0;
        in_rt_val    = '0;
        reset_errors = 0;
        drain_count  = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        if (in_ack !== 1'b0 || res_req !== 1'b0) begin
            reset_errors++;
            $display("[FAIL] %0t: in_ack or res_req not low after reset", $time);
        end
        for (int n = 0; n < NUM_WORDS; n++) begin
            make_word(word, rs, rt);
            send_word(word, rs, rt);
            gap = int'($urandom % 32'd3);
            repeat (gap) @(negedge clk);
        end
        // wait for outstanding results for a bounded time
        while ((pending != 0 || res_req || res_ack) && drain_count < DRAIN_CYCLES) begin
            @(negedge clk);
            drain_count++;
        end
        // short tail to catch a stray result
        repeat (10) @(negedge clk);
        $display("errors: %0d mismatched, %0d unexpected, %0d missing, %0d reset",
                 mismatch_count, extra_count, pending, reset_errors);
        if (mismatch_count + extra_count + pending + reset_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // slow receiver with a burst of long delays in every 100 results
    initial begin
        int          delay;
        int          served;
        logic [31:0] rnd;
        res_ack = 1'b0;
        served  = 0;
        forever begin
            @(negedge clk);
            if (res_req && !res_ack) begin
                rnd = $urandom;
                if (served % 100 >= 70) begin
                    delay = 10 + int'(rnd % 32'd7);
                end else begin
                    delay = int'(rnd % 32'd7);
                end
                repeat (delay) @(negedge clk);
                res_ack = 1'b1;
                while (res_req) @(negedge clk);
                res_ack = 1'b0;
                served++;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* project.f */
+incdir+common
common/shift_pkg.sv
hdl/shift_issue.sv
hdl/shift_queue.sv
shift_exec/block_shift.sv
shift_exec/shift_retire.sv
hdl/shift_unit_top.sv
tests/shift_unit_asserts.sv
tests/shift_unit_checker.sv
tests/shift_unit_tb.sv

/* Makefile */
# Verilator build and run for the shift unit

VERILATOR ?= verilator
TOP       ?= shift_unit_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run check clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides pass or fail, not the simulator exit code
run: compile
	-$(SIM_BIN) > $(LOG) 2>&1
	cat $(LOG)
	@$(MAKE) --no-print-directory check LOG=$(LOG)

check:
	@if grep -q "^STATUS: PASS$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
